// File: Bender.yml
package:
  name: nts_engine_stats

sources:
  - src/nts_stats_pkg.sv
  - src/nts_api.sv
  - src/nts_debug_counters.sv
  - src/nts_engine_stats.sv
  - target: simulation
    files:
      - sim/nts_stats_checker.sv
      - sim/tb_nts_engine_stats.sv

// File: sim/nts_stats_checker.sv
// Reference model of counters and identity registers, read comparison and per-test results
`timescale 1ns/1ps
`default_nettype none

module nts_stats_checker #(
  parameter logic [31:0] CORE_VERSION = "0.01"
) (
  input  wire                               i_clk,
  input  wire                               i_areset,
  input  wire                               i_api_cs,
  input  wire                               i_api_we,
  input  wire  [11:0]                       i_api_address,
  input  wire  [31:0]                       i_api_read_data,
  input  wire  nts_stats_pkg::stat_events_t i_events,
  input  wire  [7:0]                        i_test_id,
  input  wire                               i_test_end,
  output logic                              o_test_done,
  output int                                o_tests_passed,
  output int                                o_tests_failed
);

  localparam int         NUM_STATS    = 6;
  localparam logic [3:0] BLOCK_ENGINE = 4'h0;
  localparam logic [3:0] BLOCK_DEBUG  = 4'h4;
  localparam logic [7:0] STAT_BASE [NUM_STATS] = '{8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22};

  logic [63:0]          model_count [NUM_STATS];
  logic [31:0]          model_snap  [NUM_STATS];
  logic [NUM_STATS-1:0] event_bits;
  logic [31:0]          expected;
  logic                 is_read;
  int                   test_checks;
  int                   test_errors;

  // Counter order of the strobes, first strobe is counter 0
  assign event_bits = {i_events.error_txbuf, i_events.error_crypto, i_events.nts_bad_keyid,
                       i_events.nts_bad_auth, i_events.nts_bad_cookie, i_events.nts_processed};
  assign is_read    = i_api_cs && !i_api_we;

  //----------------------------------------------------------------------
  // Register map of the model
  //----------------------------------------------------------------------

  function automatic logic [31:0] engine_word(input logic [7:0] addr);
    case (addr)
      8'h00:   return "NTS_";
      8'h01:   return "ENGN";
      8'h02:   return CORE_VERSION;
      8'h08:   return 32'd1;
      default: return 32'd0;
    endcase
  endfunction

  function automatic logic [31:0] debug_word(input logic [7:0] addr);
    logic [31:0] word;
    word = '0;
    for (int k = 0; k < NUM_STATS; k++)
    begin
      if (addr == STAT_BASE[k])
        word = model_count[k][63:32];
      else if (addr == STAT_BASE[k] + 8'd1)
        word = model_snap[k];
    end
    return word;
  endfunction

  function automatic string test_name(input logic [7:0] id);
    case (id)
      8'd1:    return "identity";
      8'd2:    return "reset state";
      8'd3:    return "counting";
      8'd4:    return "snapshot coherence";
      8'd5:    return "inert accesses";
      default: return "unknown";
    endcase
  endfunction

  initial
  begin
    o_tests_passed = 0;
    o_tests_failed = 0;
    test_checks    = 0;
    test_errors    = 0;
  end

  //----------------------------------------------------------------------
  // Compare and model update at each rising edge
  //----------------------------------------------------------------------

  always @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      for (int k = 0; k < NUM_STATS; k++)
      begin
        model_count[k] <= '0;
        model_snap[k]  <= '0;
      end
      o_test_done <= 1'b0;
    end
    else
    begin
      // Read data still reflects the state before this edge
      expected = '0;
      if (is_read && i_api_address[11:8] == BLOCK_ENGINE)
        expected = engine_word(i_api_address[7:0]);
      else if (is_read && i_api_address[11:8] == BLOCK_DEBUG)
        expected = debug_word(i_api_address[7:0]);
      test_checks++;
      if (i_api_read_data !== expected)
      begin
        test_errors++;
        $display("[FAIL] %0t: access 0x%03h (cs %0b we %0b) expected 0x%08h, got 0x%08h",
                 $time, i_api_address, i_api_cs, i_api_we, expected, i_api_read_data);
      end

      for (int k = 0; k < NUM_STATS; k++)
      begin
        if (is_read && i_api_address == {BLOCK_DEBUG, STAT_BASE[k]})
          model_snap[k] <= model_count[k][31:0];  // Count before this edge's increment
        if (event_bits[k])
          model_count[k] <= model_count[k] + 64'd1;
      end

      // Result of the current test on request
      if (i_test_end && !o_test_done)
      begin
        if (test_errors == 0)
        begin
          o_tests_passed <= o_tests_passed + 1;
          $display("Test %0d %s: PASS, %0d cycles checked", i_test_id,
                   test_name(i_test_id), test_checks);
        end
        else
        begin
          o_tests_failed <= o_tests_failed + 1;
          $display("Test %0d %s: FAIL, %0d of %0d cycles wrong", i_test_id,
                   test_name(i_test_id), test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
        o_test_done <= 1'b1;
      end
      else if (!i_test_end)
        o_test_done <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: sim/tb_nts_engine_stats.sv
// Testbench top with clock, reset, random stimulus, test sequencing and summary
`timescale 1ns/1ps
`default_nettype none

module tb_nts_engine_stats;

  import nts_stats_pkg::*;

  localparam logic [31:0] TB_CORE_VERSION = "1.07";
  localparam int          DONE_TIMEOUT    = 20;  // Cycles
  localparam int          NUM_STATS       = 6;
  localparam logic [7:0]  STAT_BASE [NUM_STATS] = '{8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22};

  logic         clk = 1'b0;
  logic         areset;
  logic         api_cs;
  logic         api_we;
  logic [11:0]  api_address;
  logic [31:0]  api_write_data;
  logic [31:0]  api_read_data;
  stat_events_t events;

  logic [7:0]   test_id;
  logic         test_end;
  logic         test_done;
  int           tests_passed;
  int           tests_failed;
  int           timeouts;

  always #50 clk = ~clk;

  nts_engine_stats #(
    .CORE_VERSION (TB_CORE_VERSION)
  ) UUT (
    .i_clk            (clk),
    .i_areset         (areset),
    .i_api_cs         (api_cs),
    .i_api_we         (api_we),
    .i_api_address    (api_address),
    .i_api_write_data (api_write_data),
    .o_api_read_data  (api_read_data),
    .i_events         (events)
  );

  nts_stats_checker #(
    .CORE_VERSION (TB_CORE_VERSION)
  ) stats_checker (
    .i_clk           (clk),
    .i_areset        (areset),
    .i_api_cs        (api_cs),
    .i_api_we        (api_we),
    .i_api_address   (api_address),
    .i_api_read_data (api_read_data),
    .i_events        (events),
    .i_test_id       (test_id),
    .i_test_end      (test_end),
    .o_test_done     (test_done),
    .o_tests_passed  (tests_passed),
    .o_tests_failed  (tests_failed)
  );

  //----------------------------------------------------------------------
  // Stimulus helpers, all driven on the falling edge
  //----------------------------------------------------------------------

  task automatic drive_cycle(input logic cs, input logic we, input logic [11:0] addr,
                             input logic [31:0] wdata, input logic [5:0] ev);
    @(negedge clk);
    api_cs         = cs;
    api_we         = we;
    api_address    = addr;
    api_write_data = wdata;
    events         = stat_events_t'(ev);
  endtask

  task automatic read_reg(input logic [11:0] addr, input logic [5:0] ev);
    drive_cycle(1'b1, 1'b0, addr, $urandom, ev);
  endtask

  function automatic logic [5:0] random_events();
    logic [31:0] r;
    r = $urandom;
    return r[5:0];  // Each strobe high about half the time
  endfunction

  function automatic logic [11:0] upper_addr(input int k);
    return {4'h4, STAT_BASE[k]};
  endfunction

  function automatic logic [11:0] snap_addr(input int k);
    return {4'h4, STAT_BASE[k] + 8'd1};
  endfunction

  task automatic announce_test(input logic [7:0] id);
    @(negedge clk);
    test_id = id;
  endtask

  // Ask the checker for its verdict and wait for it
  task automatic collect_result();
    int waited;
    waited = 0;
    drive_cycle(1'b0, 1'b0, 12'h000, 32'h0, 6'h00);
    test_end = 1'b1;
    while (!test_done && waited < DONE_TIMEOUT)
    begin
      @(negedge clk);
      waited++;
    end
    if (!test_done)
    begin
      $display("Timeout: the checker gave no result for test %0d", test_id);
      timeouts++;
    end
    test_end = 1'b0;
  endtask

  //----------------------------------------------------------------------
  // Tests
  //----------------------------------------------------------------------

  task automatic check_identity();
    read_reg(12'h000, 6'h00);
    read_reg(12'h001, 6'h00);
    read_reg(12'h002, 6'h00);
    read_reg(12'h008, 6'h00);
  endtask

  task automatic check_reset_state();
    for (int k = 0; k < NUM_STATS; k++)
    begin
      read_reg(snap_addr(k), 6'h00);  // Before any upper read reloads it
      read_reg(upper_addr(k), 6'h00);
    end
  endtask

  task automatic count_random_events();
    repeat (500)
      drive_cycle(1'b0, 1'b0, 12'h000, 32'h0, random_events());
    for (int k = 0; k < NUM_STATS; k++)
    begin
      read_reg(upper_addr(k), 6'h00);
      read_reg(snap_addr(k), 6'h00);
    end
  endtask

  task automatic interleave_snapshots();
    int kind;
    int k;
    repeat (400)
    begin
      kind = $urandom % 4;
      k    = $urandom % NUM_STATS;
      if (kind < 2)
        read_reg(upper_addr(k), random_events());   // Often lands on an increment
      else if (kind == 2)
        read_reg(snap_addr(k), random_events());
      else
        drive_cycle(1'b0, 1'b0, 12'h000, 32'h0, random_events());
    end
    for (int n = 0; n < NUM_STATS; n++)
      read_reg(snap_addr(n), random_events());
  endtask

  task automatic probe_inert_accesses();
    logic [31:0] r;
    logic [7:0]  addr;
    int          kind;
    repeat (400)
    begin
      r    = $urandom;
      addr = r[15:8];
      kind = $urandom % 6;
      case (kind)
        0: drive_cycle(1'b1, 1'b1, r[0] ? upper_addr($urandom % NUM_STATS) : r[27:16],
                       $urandom, 6'h00);
        1: read_reg({4'(1 + $urandom % 3), addr}, 6'h00);
        2: read_reg({4'h0, (addr inside {8'h00, 8'h01, 8'h02, 8'h08}) ? addr | 8'h10 : addr},
                    6'h00);
        3: read_reg({4'h4, addr | 8'h40}, 6'h00);  // Past every counter address
        4: read_reg({4'(5 + $urandom % 11), addr}, 6'h00);
        default: drive_cycle(1'b0, r[1], r[27:16], $urandom, 6'h00);
      endcase
    end
    // Follow-up reads against the model
    for (int k = 0; k < NUM_STATS; k++)
    begin
      read_reg(snap_addr(k), 6'h00);
      read_reg(upper_addr(k), 6'h00);
      read_reg(snap_addr(k), 6'h00);
    end
  endtask

  //----------------------------------------------------------------------
  // Sequencing
  //----------------------------------------------------------------------

  initial
  begin
    void'($urandom(32'h4206d85b));
    timeouts       = 0;
    test_id        = 8'd0;
    test_end       = 1'b0;
    areset         = 1'b1;
    api_cs         = 1'b0;
    api_we         = 1'b0;
    api_address    = 12'h000;
    api_write_data = 32'h0;
    events         = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    areset = 1'b0;

    announce_test(8'd1);
    check_identity();
    collect_result();
    announce_test(8'd2);
    check_reset_state();
    collect_result();
    announce_test(8'd3);
    count_random_events();
    collect_result();
    announce_test(8'd4);
    interleave_snapshots();
    collect_result();
    announce_test(8'd5);
    probe_inert_accesses();
    collect_result();

    @(negedge clk);
    $display("Summary: %0d tests passed, %0d tests failed", tests_passed,
             tests_failed + timeouts);
    if (tests_failed == 0 && timeouts == 0 && tests_passed == 5)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/nts_api.sv
// API block decoder, engine identity registers and read data merge
`timescale 1ns/1ps
`default_nettype none

module nts_api #(
  parameter logic [31:0] CORE_VERSION = 32'h30_2e_30_31 // "0.01"
) (
  input  wire                        i_api_cs,
  input  wire                        i_api_we,
  input  wire  [11:0]                i_api_address,
  input  wire  nts_stats_pkg::api_data_t i_api_write_data,
  output nts_stats_pkg::api_data_t   o_api_read_data,

  output nts_stats_pkg::api_req_t    o_req,
  output logic                       o_debug_cs,
  input  wire  nts_stats_pkg::api_data_t i_debug_read_data
);

  import nts_stats_pkg::*;

  //--------------------------------------------------------------------
  // Address split
  //--------------------------------------------------------------------

  api_block_e block;
  api_req_t   req;
  api_data_t  engine_read_data;
  logic       api_read;

  assign block = api_block_e'(i_api_address[11:8]);

  always_comb
  begin
    req.we    = i_api_we;
    req.addr  = i_api_address[7:0];
    req.wdata = i_api_write_data;
  end

  assign o_req      = req;
  assign o_debug_cs = i_api_cs && (block == BLK_DEBUG);
  assign api_read   = i_api_cs && !i_api_we;

  //--------------------------------------------------------------------
  // Engine identity block
  //--------------------------------------------------------------------

  always_comb
  begin
    case (req.addr)
      ADDR_NAME0:   engine_read_data = CORE_NAME0;
      ADDR_NAME1:   engine_read_data = CORE_NAME1;
      ADDR_VERSION: engine_read_data = CORE_VERSION;
      ADDR_CTRL:    engine_read_data = 32'h0000_0001; // Engine always enabled
      default:      engine_read_data = '0;
    endcase
  end

  //--------------------------------------------------------------------
  // Read data merge
  //--------------------------------------------------------------------

  always_comb
  begin
    o_api_read_data = '0;
    if (api_read)
    begin
      case (block)
        BLK_ENGINE: o_api_read_data = engine_read_data;
        BLK_DEBUG:  o_api_read_data = i_debug_read_data;
        // Clock, key memory and cookie blocks not present
        BLK_CLOCK,
        BLK_KEYMEM,
        BLK_COOKIE: o_api_read_data = '0;
        default:    o_api_read_data = '0;
      endcase
    end
  end

  // Counter block must never see a select outside an API access
  always_comb
  begin
    a_debug_cs_in_access : assert #0 (i_api_cs || !o_debug_cs)
      else $error("debug select raised without API chip select");
  end

endmodule

`default_nettype wire

// File: src/nts_debug_counters.sv
// Six 64-bit event counters with lower word snapshots and their read decoder
`timescale 1ns/1ps
`default_nettype none

module nts_debug_counters (
  input  wire                            i_clk,
  input  wire                            i_areset,
  input  wire  nts_stats_pkg::stat_events_t i_events,
  input  wire                            i_cs,
  input  wire  nts_stats_pkg::api_req_t  i_req,
  output nts_stats_pkg::api_data_t       o_read_data
);

  import nts_stats_pkg::*;

  //--------------------------------------------------------------------
  // Storage
  //--------------------------------------------------------------------

  logic [63:0]           counter  [STAT_COUNT];
  logic [31:0]           snapshot [STAT_COUNT];
  logic [STAT_COUNT-1:0] event_bits;
  logic [STAT_COUNT-1:0] snap_load;  // One hot, upper word read in progress
  logic                  rd;

  assign event_bits = i_events;        // Bit order follows stat_id_e
  assign rd         = i_cs && !i_req.we;

  //--------------------------------------------------------------------
  // Read decoder
  //--------------------------------------------------------------------

  always_comb
  begin
    o_read_data = '0;
    snap_load   = '0;
    if (rd)
    begin
      for (int i = 0; i < STAT_COUNT; i++)
      begin
        if (i_req.addr == STAT_BASE_ADDR[i])
        begin
          o_read_data  = counter[i][63:32];
          snap_load[i] = 1'b1;  // Freeze low half for the next read
        end
        else if (i_req.addr == api_addr_t'(STAT_BASE_ADDR[i] + 8'd1))
        begin
          o_read_data = snapshot[i];
        end
      end
    end
  end

  //--------------------------------------------------------------------
  // Counters and snapshots
  //--------------------------------------------------------------------

  for (genvar i = 0; i < STAT_COUNT; i++)
  begin : g_stat
    localparam stat_id_e ID = stat_id_e'(i);

    always_ff @(posedge i_clk or posedge i_areset)
    begin
      if (i_areset)
      begin
        counter[ID]  <= '0;
        snapshot[ID] <= '0;
      end
      else
      begin
        if (event_bits[ID])
          counter[ID] <= counter[ID] + 64'd1;
        // Takes the pre-increment value, matching the upper word just read
        if (snap_load[ID])
          snapshot[ID] <= counter[ID][31:0];
      end
    end

    // Counters only ever step by one, whatever the API does
    a_count_step : assert property (
      @(posedge i_clk) disable iff (i_areset)
      (counter[ID] != $past(counter[ID])) |-> (counter[ID] == $past(counter[ID]) + 64'd1)
    ) else $error("counter %0d changed by more than one", i);
  end

  // Base addresses in the package table must stay distinct
  a_snap_onehot : assert property (
    @(posedge i_clk) disable iff (i_areset)
    $onehot0(snap_load)
  ) else $error("more than one snapshot load in a cycle");

endmodule

`default_nettype wire

// File: src/nts_engine_stats.sv
// Top level joining the API decoder and the debug statistics counters
`timescale 1ns/1ps
`default_nettype none

module nts_engine_stats #(
  parameter logic [31:0] CORE_VERSION = 32'h30_2e_30_31 // "0.01"
) (
  input  wire                               i_clk,
  input  wire                               i_areset,  // Async, active high

  input  wire                               i_api_cs,
  input  wire                               i_api_we,
  input  wire  [11:0]                       i_api_address,
  input  wire  [31:0]                       i_api_write_data,
  output logic [31:0]                       o_api_read_data,

  input  wire  nts_stats_pkg::stat_events_t i_events
);

  import nts_stats_pkg::*;

  api_req_t  req;
  logic      debug_cs;
  api_data_t debug_read_data;

  //--------------------------------------------------------------------
  // API decoder
  //--------------------------------------------------------------------

  nts_api #(
    .CORE_VERSION (CORE_VERSION)
  ) api (
    .i_api_cs          (i_api_cs),
    .i_api_we          (i_api_we),
    .i_api_address     (i_api_address),
    .i_api_write_data  (i_api_write_data),
    .o_api_read_data   (o_api_read_data),
    .o_req             (req),
    .o_debug_cs        (debug_cs),
    .i_debug_read_data (debug_read_data)
  );

  //--------------------------------------------------------------------
  // Statistics counters
  //--------------------------------------------------------------------

  nts_debug_counters debug (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_events    (i_events),
    .i_cs        (debug_cs),
    .i_req       (req),
    .o_read_data (debug_read_data)
  );

endmodule

`default_nettype wire

// File: src/nts_stats_pkg.sv
// API block codes, register map, identity words, counter ids and event and request structs
`default_nettype none

package nts_stats_pkg;

  //--------------------------------------------------------------------
  // API address map
  //--------------------------------------------------------------------

  // Upper nibble of the 12-bit external address
  typedef enum logic [3:0] {
    BLK_ENGINE = 4'h0,
    BLK_CLOCK  = 4'h1,
    BLK_KEYMEM = 4'h2,
    BLK_COOKIE = 4'h3,
    BLK_DEBUG  = 4'h4
  } api_block_e;

  typedef logic [7:0]  api_addr_t;  // Register address inside a block
  typedef logic [31:0] api_data_t;

  // Engine identity block
  localparam api_addr_t ADDR_NAME0   = 8'h00;
  localparam api_addr_t ADDR_NAME1   = 8'h01;
  localparam api_addr_t ADDR_VERSION = 8'h02;
  localparam api_addr_t ADDR_CTRL    = 8'h08;

  localparam logic [31:0] CORE_NAME0 = 32'h4e_54_53_5f; // "NTS_"
  localparam logic [31:0] CORE_NAME1 = 32'h45_4e_47_4e; // "ENGN"

  //--------------------------------------------------------------------
  // Debug statistics counters
  //--------------------------------------------------------------------

  typedef enum logic [2:0] {
    STAT_NTS_PROCESSED  = 3'd0,
    STAT_NTS_BAD_COOKIE = 3'd1,
    STAT_NTS_BAD_AUTH   = 3'd2,
    STAT_NTS_BAD_KEYID  = 3'd3,
    STAT_ERROR_CRYPTO   = 3'd4,
    STAT_ERROR_TXBUF    = 3'd5
  } stat_id_e;

  localparam int STAT_COUNT = 6;

  // Upper word at base, lower word snapshot at base + 1
  localparam api_addr_t STAT_BASE_ADDR [STAT_COUNT] = '{
    8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22
  };

  // Declared MSB first, so bit n is the strobe of stat_id_e value n
  typedef struct packed {
    logic error_txbuf;
    logic error_crypto;
    logic nts_bad_keyid;
    logic nts_bad_auth;
    logic nts_bad_cookie;
    logic nts_processed;
  } stat_events_t;

  // Internal request toward the API blocks
  typedef struct packed {
    logic      we;
    api_addr_t addr;
    api_data_t wdata;
  } api_req_t;

endpackage

`default_nettype wire

// File: verilog.f
src/nts_stats_pkg.sv
src/nts_api.sv
src/nts_debug_counters.sv
src/nts_engine_stats.sv
sim/nts_stats_checker.sv
sim/tb_nts_engine_stats.sv
